//--- Makefile
# Verilator lint, simulation and clean for the core shell

TOP := tb_core_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/core_checker.sv
////////////////////
// reference model and comparator for the core shell
// per test report and closing counts
////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_checker import bridge_pkg::*, video_pkg::*; #(
  parameter int WRITE_GAP = 7
) (
  input wire logic                   clk_74a,
  input wire logic                   pll_core_locked,
  input wire logic                   bridge_endian_little,
  input wire bridge_word_t           bridge_addr,
  input wire logic                   bridge_wr,
  input wire bridge_word_t           bridge_wr_data,
  input wire logic                   dataslot_requestread,
  input wire logic                   dataslot_requestwrite,
  input wire logic                   dataslot_allcomplete,
  input wire bridge_word_t           datatable_q,
  input wire logic [SRAM_SIZE_W-1:0] sram_size,
  input wire logic [DT_ADDR_W-1:0]   datatable_addr,
  input wire logic                   datatable_wren,
  input wire bridge_word_t           datatable_data,
  input wire bridge_word_t           rom_file_size,
  input wire logic                   rom_download,
  input wire logic                   save_download,
  input wire logic                   rom_wr,
  input wire logic [ROM_ADDR_W-1:0]  rom_addr,
  input wire rom_word_t              rom_data,
  input wire logic                   save_wr,
  input wire logic [SAVE_ADDR_W-1:0] save_addr,
  input wire save_byte_t             save_data,
  input wire logic                   core_hblank,
  input wire logic                   core_vblank,
  input wire logic                   core_hsync,
  input wire logic                   core_vsync,
  input wire rgb_t                   core_rgb,
  input wire logic                   video_de,
  input wire rgb_t                   video_rgb,
  input wire logic                   video_hs,
  input wire logic                   video_vs
);

  int tests_run = 0;
  int tests_failed = 0;
  int total_errors = 0;
  int test_errors = 0;

  // inputs seen at the previous falling edge
  logic p_rst = 1'b0;
  logic p_rd, p_wr, p_ac, p_hb, p_vb, p_hs, p_vs;
  bridge_word_t p_q;
  logic [SRAM_SIZE_W-1:0] p_size;
  rgb_t p_rgb;
  logic p_acc [2];

  // expected state
  int div;
  logic e_wren, e_rom_dl, e_save_dl, e_ac_prev, e_de, e_hs, e_vs, hs_prev, vs_prev;
  bridge_word_t e_data, e_rfs, ld_base [2], ld_word [2];
  int ld_cnt [2];

  // loader 0 is rom halfwords, loader 1 is save bytes
  function automatic int pieces_of(input int l);
    return (l == 0) ? 2 : 4;
  endfunction

  function automatic int width_of(input int l);
    return (l == 0) ? 16 : 8;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED t=%0t %s got %h expected %h", $time, what, got, exp);
    test_errors++;
    total_errors++;
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic reset_model();
    div = 0;
    {e_wren, e_rom_dl, e_save_dl, e_ac_prev} = '0;
    {e_de, e_hs, e_vs, hs_prev, vs_prev} = '0;
    e_rfs = '0;
    ld_cnt[0] = -1;
    ld_cnt[1] = -1;
  endtask

  ////////////////////
  // one clock of the reference model
  task automatic step_model();
    e_wren = (div >= 5);
    if (e_wren) e_data = (p_size == 0) ? 32'h0 : (32'(SAVE_SIZE_BASE) << p_size);
    if (div == 4) e_rfs = p_q;
    div = (div + 1) % 8;
    // set wins over clear
    if (p_wr) e_rom_dl = 1'b1;
    else if (p_ac) e_rom_dl = 1'b0;
    if (p_rd || p_wr) e_save_dl = 1'b1;
    else if (p_ac && !e_ac_prev) e_save_dl = 1'b0;
    e_ac_prev = p_ac;
    e_de = !(p_hb || p_vb);
    e_hs = p_hs && !hs_prev;
    e_vs = p_vs && !vs_prev;
    hs_prev = p_hs;
    vs_prev = p_vs;
    for (int l = 0; l < 2; l++) begin
      if (p_acc[l]) ld_cnt[l] = 0;
      else if (ld_cnt[l] >= 0) ld_cnt[l]++;
      if (ld_cnt[l] > pieces_of(l) * WRITE_GAP) ld_cnt[l] = -1;
    end
  endtask

  // a pulse every WRITE_GAP cycles from the accept
  task automatic check_loader(input int l, input logic en, input logic [31:0] addr,
                              input logic [31:0] data);
    int i;
    logic exp_en;
    logic [31:0] mask;
    i = ld_cnt[l] / WRITE_GAP;
    exp_en = ld_cnt[l] >= 0 && ld_cnt[l] % WRITE_GAP == 0 && i < pieces_of(l);
    mask = (l == 0) ? 32'h1ff_ffff : 32'hf_ffff;
    check($sformatf("loader %0d write enable", l), 32'(en), 32'(exp_en));
    if (exp_en && en) begin
      check($sformatf("loader %0d address piece %0d", l, i), addr,
            (ld_base[l] + 32'(i * width_of(l) / 8)) & mask);
      check($sformatf("loader %0d data piece %0d", l, i), data,
            (ld_word[l] >> (32 - width_of(l) * (i + 1))) & ((32'h1 << width_of(l)) - 1));
    end
  endtask

  always @(negedge clk_74a) begin
    if (!pll_core_locked) reset_model();
    else if (p_rst) step_model();
    // big endian bridge only
    check("bridge_endian_little", 32'(bridge_endian_little), 32'h0);
    check("datatable_wren", 32'(datatable_wren), 32'(e_wren));
    check("datatable_addr", 32'(datatable_addr),
          e_wren ? DT_SAVE_SIZE_ADDR : DT_ROM_SIZE_ADDR);
    if (e_wren) check("datatable_data", datatable_data, e_data);
    check("rom_file_size", rom_file_size, e_rfs);
    check("rom_download", 32'(rom_download), 32'(e_rom_dl));
    check("save_download", 32'(save_download), 32'(e_save_dl));
    check("video_de", 32'(video_de), 32'(e_de));
    check("video_hs", 32'(video_hs), 32'(e_hs));
    check("video_vs", 32'(video_vs), 32'(e_vs));
    check("video_rgb", 32'(video_rgb), e_de ? 32'(p_rgb) : 32'h0);
    check_loader(0, rom_wr, 32'(rom_addr), 32'(rom_data));
    check_loader(1, save_wr, 32'(save_addr), 32'(save_data));
    // inputs for the next rising edge
    for (int l = 0; l < 2; l++) begin
      p_acc[l] = pll_core_locked && bridge_wr &&
                 bridge_addr[31:28] == ((l == 0) ? REGION_ROM : REGION_SAVE) &&
                 (ld_cnt[l] < 0 || ld_cnt[l] + 1 >= pieces_of(l) * WRITE_GAP + 1);
      if (p_acc[l]) begin
        ld_base[l] = bridge_addr;
        ld_word[l] = bridge_wr_data;
      end
    end
    {p_rst, p_rd, p_wr, p_ac} = {pll_core_locked, dataslot_requestread,
                                 dataslot_requestwrite, dataslot_allcomplete};
    {p_hb, p_vb, p_hs, p_vs} = {core_hblank, core_vblank, core_hsync, core_vsync};
    p_q = datatable_q;
    p_size = sram_size;
    p_rgb = core_rgb;
  end

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic summary();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
  endtask

endmodule

`default_nettype wire

//--- bench/core_stimulus.txt
# op operands in hex: W addr data | S rd wr ac | D sram_size datatable_q
# V cycles | I cycles | T test_name
I 4
T after_reset
W 10000100 a1b2c3d4
W 1000020a 12345678
T rom_loader
W 20000010 deadbeef
W 00000040 11111111
W 10000080 22222222
W f0000000 33333333
W 200fffff 0badcafe
T save_loader
S 0 1 0
S 0 0 1
S 1 0 1
S 0 0 0
S 1 0 0
S 0 0 1
S 0 1 1
T download_flags
D 0 00001234
D 3 00abcdef
D f 7fffffff
T data_table
V 30
I 3
T video

//--- bench/tb_core_top.sv
////////////////////
// testbench top for the core shell
// clock, reset, stimulus file reader, watchdog
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_core_top import bridge_pkg::*, video_pkg::*; ();

  localparam int WRITE_GAP      = 7;
  localparam int CYCLES_PER_OP  = 64;
  // host spacing between bridge words, widest loader has 4 pieces
  localparam int WRITE_SPACING  = 4 * WRITE_GAP + 2;

  logic                   clk_74a;
  logic                   pll_core_locked;
  logic                   bridge_endian_little;
  bridge_word_t           bridge_addr;
  logic                   bridge_wr;
  bridge_word_t           bridge_wr_data;
  logic                   dataslot_requestread;
  logic                   dataslot_requestwrite;
  logic                   dataslot_allcomplete;
  bridge_word_t           datatable_q;
  logic [SRAM_SIZE_W-1:0] sram_size;
  logic [DT_ADDR_W-1:0]   datatable_addr;
  logic                   datatable_wren;
  bridge_word_t           datatable_data;
  bridge_word_t           rom_file_size;
  logic                   rom_download;
  logic                   save_download;
  logic                   rom_wr;
  logic [ROM_ADDR_W-1:0]  rom_addr;
  rom_word_t              rom_data;
  logic                   save_wr;
  logic [SAVE_ADDR_W-1:0] save_addr;
  save_byte_t             save_data;
  logic                   core_hblank;
  logic                   core_vblank;
  logic                   core_hsync;
  logic                   core_vsync;
  rgb_t                   core_rgb;
  logic                   video_de;
  rgb_t                   video_rgb;
  logic                   video_hs;
  logic                   video_vs;

  int op_lines = 0;
  int bad_ops = 0;
  logic ops_counted = 1'b0;

  core_top #(.WRITE_GAP(WRITE_GAP)) u_core_top (.*);

  core_checker #(.WRITE_GAP(WRITE_GAP)) u_checker (.*);

  // 20 ns clock
  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_74a);
  endtask

  // one bridge word, then the host gap
  task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr      <= 1'b0;
    idle_cycles(WRITE_SPACING);
  endtask

  // request strobes last one cycle, allcomplete stays as given
  task automatic slot_strobe(input logic rd, input logic wr, input logic ac);
    @(posedge clk_74a);
    dataslot_requestread  <= rd;
    dataslot_requestwrite <= wr;
    dataslot_allcomplete  <= ac;
    @(posedge clk_74a);
    dataslot_requestread  <= 1'b0;
    dataslot_requestwrite <= 1'b0;
    idle_cycles(2);
  endtask

  task automatic table_inputs(input logic [SRAM_SIZE_W-1:0] code, input bridge_word_t q);
    @(posedge clk_74a);
    sram_size   <= code;
    datatable_q <= q;
    idle_cycles(20);
  endtask

  // random blanks, syncs and colour for n cycles
  task automatic video_run(input int n);
    repeat (n) begin
      @(posedge clk_74a);
      core_hblank <= 1'($urandom);
      core_vblank <= 1'($urandom);
      core_hsync  <= 1'($urandom);
      core_vsync  <= 1'($urandom);
      core_rgb    <= rgb_t'($urandom);
    end
  endtask

  // operation lines, comments start with #
  function automatic logic is_op(input string line);
    return line.len() > 1 && line[0] != "#";
  endfunction

  initial begin
    int fd;
    string line;
    byte opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [8*32-1:0] name;
    void'($urandom(32'h1667_ef96));
    pll_core_locked       = 1'b0;
    bridge_addr           = '0;
    bridge_wr             = 1'b0;
    bridge_wr_data        = '0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    datatable_q           = '0;
    sram_size             = '0;
    core_hblank           = 1'b1;
    core_vblank           = 1'b1;
    core_hsync            = 1'b0;
    core_vsync            = 1'b0;
    core_rgb              = '0;
    fd = $fopen("bench/core_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file bench/core_stimulus.txt");
      $display(">>> FAIL");
      $finish;
    end else begin
      // first pass only counts operations for the watchdog
      while ($fgets(line, fd) > 0) begin
        if (is_op(line)) op_lines++;
      end
      ops_counted = 1'b1;
      $fclose(fd);
      fd = $fopen("bench/core_stimulus.txt", "r");
      idle_cycles(3);
      pll_core_locked <= 1'b1;
      while ($fgets(line, fd) > 0) begin
        if (is_op(line)) begin
          void'($sscanf(line, "%c", opc));
          case (opc)
            "W": begin
              void'($sscanf(line, "%c %h %h", opc, a, b));
              bridge_write(a, b);
            end
            "S": begin
              void'($sscanf(line, "%c %h %h %h", opc, a, b, c));
              slot_strobe(a[0], b[0], c[0]);
            end
            "D": begin
              void'($sscanf(line, "%c %h %h", opc, a, b));
              table_inputs(a[SRAM_SIZE_W-1:0], b);
            end
            "V": begin
              void'($sscanf(line, "%c %h", opc, a));
              video_run(int'(a));
            end
            "I": begin
              void'($sscanf(line, "%c %h", opc, a));
              idle_cycles(int'(a));
            end
            "T": begin
              void'($sscanf(line, "%c %s", opc, name));
              idle_cycles(2);
              u_checker.end_test($sformatf("%0s", name));
            end
            default: begin
              $display("unknown stimulus operation: %s", line);
              bad_ops++;
            end
          endcase
        end
      end
      $fclose(fd);
      u_checker.summary();
      if (u_checker.total_errors == 0 && u_checker.tests_run > 0 && bad_ops == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

  // watchdog scaled by the number of operations
  initial begin
    wait (ops_counted);
    repeat (op_lines * CYCLES_PER_OP) @(posedge clk_74a);
    $display("timeout: stimulus did not finish within %0d cycles", op_lines * CYCLES_PER_OP);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/bridge_pkg.sv
////////////////////
// bridge word type and loader region codes
// loader payload types and write address widths
// data-table addresses and save size encoding
////////////////////

`default_nettype none

package bridge_pkg;

  // one bridge address or data word
  typedef logic [31:0] bridge_word_t;

  // upper address nibble claimed by each loader
  localparam logic [3:0] REGION_ROM  = 4'h1;
  localparam logic [3:0] REGION_SAVE = 4'h2;

  // rom memory takes halfwords, save memory takes bytes
  typedef logic [15:0] rom_word_t;
  typedef logic [7:0]  save_byte_t;

  // memory side address widths
  localparam int ROM_ADDR_W  = 25;
  localparam int SAVE_ADDR_W = 20;

  ////////////////////
  // data table port
  localparam int DT_DIV_W          = 3;
  localparam int DT_ADDR_W         = 10;
  // slot 0 size word, then slot 1 size word
  localparam int DT_ROM_SIZE_ADDR  = 1;
  localparam int DT_SAVE_SIZE_ADDR = 3;

  // save bytes = base << code, code 0 means no save
  localparam int SAVE_SIZE_BASE = 1024;
  localparam int SRAM_SIZE_W    = 4;

endpackage

`default_nettype wire

//--- logic/bridge_slot_loader.sv
////////////////////
// loader for one bridge region
// splits each accepted word into paced memory writes
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bridge_slot_loader import bridge_pkg::*; #(
  parameter type         word_t    = rom_word_t,
  parameter logic [3:0]  REGION    = REGION_ROM,
  parameter int          ADDR_W    = ROM_ADDR_W,
  parameter int          WRITE_GAP = 7
) (
  input  wire logic              clk_74a,
  input  wire logic              pll_core_locked,
  input  wire bridge_word_t      bridge_addr,
  input  wire logic              bridge_wr,
  input  wire bridge_word_t      bridge_wr_data,
  output logic                   write_en,
  output logic [ADDR_W-1:0]      write_addr,
  output word_t                  write_data
);

  // piece geometry from the payload type
  localparam int PIECE_W     = $bits(word_t);
  localparam int PIECES      = 32 / PIECE_W;
  localparam int PIECE_BYTES = PIECE_W / 8;
  localparam int PIDX_W      = $clog2(PIECES + 1);
  localparam int GAP_W       = $clog2(WRITE_GAP + 1);

  logic               busy;
  logic [PIDX_W-1:0]  piece_idx;
  logic [GAP_W-1:0]   gap_cnt;
  bridge_word_t       shift_r;

  logic accept;
  logic gap_done;
  logic emit_next;

  // new word only when idle and the upper nibble matches
  assign accept    = bridge_wr && (bridge_addr[31:28] == REGION) && !busy;
  assign gap_done  = (gap_cnt == '0);
  // piece_idx == PIECES marks the trailing gap after the last piece
  assign emit_next = busy && gap_done && (piece_idx != PIDX_W'(PIECES));

  ////////////////////
  // pacing control
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      busy      <= 1'b0;
      write_en  <= 1'b0;
      piece_idx <= '0;
      gap_cnt   <= '0;
    end else begin
      // one cycle strobe per piece
      write_en <= accept || emit_next;
      if (accept) begin
        // first piece leaves now, next one waits a full gap
        busy      <= 1'b1;
        piece_idx <= PIDX_W'(1);
        gap_cnt   <= GAP_W'(WRITE_GAP - 1);
      end else if (busy) begin
        if (!gap_done) begin
          gap_cnt <= gap_cnt - 1'b1;
        end else if (piece_idx == PIDX_W'(PIECES)) begin
          // trailing gap over, ready for the next word
          busy <= 1'b0;
        end else begin
          piece_idx <= piece_idx + 1'b1;
          gap_cnt   <= GAP_W'(WRITE_GAP - 1);
        end
      end
    end
  end

  ////////////////////
  // word latch and piece output
  always_ff @(posedge clk_74a) begin
    if (accept) begin
      // big endian, top piece goes to the base address
      write_addr <= bridge_addr[ADDR_W-1:0];
      write_data <= word_t'(bridge_wr_data[31 -: PIECE_W]);
      shift_r    <= bridge_wr_data << PIECE_W;
    end else if (emit_next) begin
      write_addr <= write_addr + ADDR_W'(PIECE_BYTES);
      write_data <= word_t'(shift_r[31 -: PIECE_W]);
      shift_r    <= shift_r << PIECE_W;
    end
  end

endmodule

`default_nettype wire

//--- logic/core_top.sv
////////////////////
// bridge facing core shell
// two slot loaders, data-table sequencer, video output stage
////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_top import bridge_pkg::*, video_pkg::*; #(
  parameter int WRITE_GAP = 7
) (
  input  wire logic                   clk_74a,
  input  wire logic                   pll_core_locked,
  // bridge bus, write side only
  output logic                        bridge_endian_little,
  input  wire bridge_word_t           bridge_addr,
  input  wire logic                   bridge_wr,
  input  wire bridge_word_t           bridge_wr_data,
  // host data-slot strobes
  input  wire logic                   dataslot_requestread,
  input  wire logic                   dataslot_requestwrite,
  input  wire logic                   dataslot_allcomplete,
  // data table port
  input  wire bridge_word_t           datatable_q,
  input  wire logic [SRAM_SIZE_W-1:0] sram_size,
  output logic [DT_ADDR_W-1:0]        datatable_addr,
  output logic                        datatable_wren,
  output bridge_word_t                datatable_data,
  output bridge_word_t                rom_file_size,
  output logic                        rom_download,
  output logic                        save_download,
  // rom memory writes
  output logic                        rom_wr,
  output logic [ROM_ADDR_W-1:0]       rom_addr,
  output rom_word_t                   rom_data,
  // save memory writes
  output logic                        save_wr,
  output logic [SAVE_ADDR_W-1:0]      save_addr,
  output save_byte_t                  save_data,
  // video from the core
  input  wire logic                   core_hblank,
  input  wire logic                   core_vblank,
  input  wire logic                   core_hsync,
  input  wire logic                   core_vsync,
  input  wire rgb_t                   core_rgb,
  // video to the scaler
  output logic                        video_de,
  output rgb_t                        video_rgb,
  output logic                        video_hs,
  output logic                        video_vs
);

  // big endian bridge
  assign bridge_endian_little = 1'b0;

  ////////////////////
  // loaders share the broadcast write bus

  // region 1, halfwords into rom
  bridge_slot_loader #(
    .word_t    (rom_word_t),
    .REGION    (REGION_ROM),
    .ADDR_W    (ROM_ADDR_W),
    .WRITE_GAP (WRITE_GAP)
  ) u_rom_loader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .write_en        (rom_wr),
    .write_addr      (rom_addr),
    .write_data      (rom_data)
  );

  // region 2, bytes into save memory
  bridge_slot_loader #(
    .word_t    (save_byte_t),
    .REGION    (REGION_SAVE),
    .ADDR_W    (SAVE_ADDR_W),
    .WRITE_GAP (WRITE_GAP)
  ) u_save_loader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .write_en        (save_wr),
    .write_addr      (save_addr),
    .write_data      (save_data)
  );

  ////////////////////
  // data slots and video

  dataslot_sequencer u_dataslot_sequencer (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .datatable_q           (datatable_q),
    .sram_size             (sram_size),
    .datatable_addr        (datatable_addr),
    .datatable_wren        (datatable_wren),
    .datatable_data        (datatable_data),
    .rom_file_size         (rom_file_size),
    .rom_download          (rom_download),
    .save_download         (save_download)
  );

  video_out_stage u_video_out_stage (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_hblank     (core_hblank),
    .core_vblank     (core_vblank),
    .core_hsync      (core_hsync),
    .core_vsync      (core_vsync),
    .core_rgb        (core_rgb),
    .video_de        (video_de),
    .video_rgb       (video_rgb),
    .video_hs        (video_hs),
    .video_vs        (video_vs)
  );

endmodule

`default_nettype wire

//--- logic/dataslot_sequencer.sv
////////////////////
// data-table time sharing between rom size read and save size write
// rom and save download levels
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dataslot_sequencer import bridge_pkg::*; (
  input  wire logic                   clk_74a,
  input  wire logic                   pll_core_locked,
  input  wire logic                   dataslot_requestread,
  input  wire logic                   dataslot_requestwrite,
  input  wire logic                   dataslot_allcomplete,
  input  wire bridge_word_t           datatable_q,
  input  wire logic [SRAM_SIZE_W-1:0] sram_size,
  output logic [DT_ADDR_W-1:0]        datatable_addr,
  output logic                        datatable_wren,
  output bridge_word_t                datatable_data,
  output bridge_word_t                rom_file_size,
  output logic                        rom_download,
  output logic                        save_download
);

  // divider slots
  localparam logic [DT_DIV_W-1:0] DIV_CAPTURE     = DT_DIV_W'(4);
  localparam logic [DT_DIV_W-1:0] DIV_WRITE_FIRST = DT_DIV_W'(5);

  logic [DT_DIV_W-1:0] datatable_div;
  logic                allcomplete_prev;
  bridge_word_t        save_size_bytes;

  // save size code to byte count
  assign save_size_bytes = (sram_size == '0) ? '0 :
                           (bridge_word_t'(SAVE_SIZE_BASE) << sram_size);

  ////////////////////
  // data table port
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_div  <= '0;
      // port rests on the read address like the read slots
      datatable_addr <= DT_ADDR_W'(DT_ROM_SIZE_ADDR);
      datatable_wren <= 1'b0;
      rom_file_size  <= '0;
    end else begin
      // free running, wraps after 7
      datatable_div <= datatable_div + 1'b1;
      if (datatable_div >= DIV_WRITE_FIRST) begin
        // last three slots write the save size
        datatable_wren <= 1'b1;
        datatable_addr <= DT_ADDR_W'(DT_SAVE_SIZE_ADDR);
      end else begin
        datatable_wren <= 1'b0;
        datatable_addr <= DT_ADDR_W'(DT_ROM_SIZE_ADDR);
        // read data has settled by the last read slot
        if (datatable_div == DIV_CAPTURE) begin
          rom_file_size <= datatable_q;
        end
      end
    end
  end

  // write data follows the same slots as wren
  always_ff @(posedge clk_74a) begin
    if (datatable_div >= DIV_WRITE_FIRST) begin
      datatable_data <= save_size_bytes;
    end
  end

  ////////////////////
  // download levels, set wins over clear
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rom_download     <= 1'b0;
      save_download    <= 1'b0;
      allcomplete_prev <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;
      if (dataslot_requestwrite) begin
        rom_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        rom_download <= 1'b0;
      end
      // save level drops only on the allcomplete rising edge
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (dataslot_allcomplete && !allcomplete_prev) begin
        save_download <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/video_out_stage.sv
////////////////////
// registered video outputs
// blank masking and single cycle sync pulses
////////////////////

`timescale 1ns/1ps
`default_nettype none

module video_out_stage import video_pkg::*; (
  input  wire logic  clk_74a,
  input  wire logic  pll_core_locked,
  input  wire logic  core_hblank,
  input  wire logic  core_vblank,
  input  wire logic  core_hsync,
  input  wire logic  core_vsync,
  input  wire rgb_t  core_rgb,
  output logic       video_de,
  output rgb_t       video_rgb,
  output logic       video_hs,
  output logic       video_vs
);

  logic active;
  logic hs_prev;
  logic vs_prev;

  // active area when neither blank is set
  assign active = !(core_hblank || core_vblank);

  // de and sync pulses
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
    end else begin
      video_de <= active;
      // rising edge of core sync only
      video_hs <= core_hsync && !hs_prev;
      video_vs <= core_vsync && !vs_prev;
      hs_prev  <= core_hsync;
      vs_prev  <= core_vsync;
    end
  end

  // colour lines up with de
  always_ff @(posedge clk_74a) begin
    video_rgb <= active ? core_rgb : RGB_BLACK;
  end

endmodule

`default_nettype wire

//--- logic/video_pkg.sv
////////////////////
// colour type for the video output path
////////////////////

`default_nettype none

package video_pkg;

  // bits per colour channel
  localparam int CHANNEL_W = 8;

  // 24-bit pixel, red in the top byte
  typedef struct packed {
    logic [CHANNEL_W-1:0] r;
    logic [CHANNEL_W-1:0] g;
    logic [CHANNEL_W-1:0] b;
  } rgb_t;

  // colour driven outside the active area
  localparam rgb_t RGB_BLACK = '{r: '0, g: '0, b: '0};

endpackage

`default_nettype wire

//--- sim.f
logic/bridge_pkg.sv
logic/video_pkg.sv
logic/bridge_slot_loader.sv
logic/dataslot_sequencer.sv
logic/video_out_stage.sv
logic/core_top.sv
bench/core_checker.sv
bench/tb_core_top.sv
